/* logic/tq_dc_pkg.sv */
`default_nettype none

package tq_dc_pkg;

    // signed coefficient whose raw inputs stay within 12 bits of magnitude
    // so the four-term hadamard sums cannot overflow
    typedef logic signed [14:0] coeff_t;

    // quantization parameter from 0 to 51
    typedef logic [5:0] qp_t;

    // quantized signed level
    typedef logic signed [14:0] level_t;

    // one 2x2 chroma dc block with its qp
    typedef struct packed {
        qp_t    qp;
        coeff_t c00;
        coeff_t c01;
        coeff_t c10;
        coeff_t c11;
    } dc_block_t;

    // four quantized levels of one block
    typedef struct packed {
        level_t l00;
        level_t l01;
        level_t l10;
        level_t l11;
    } level_block_t;

endpackage

`default_nettype wire

/* logic/tq_dc_hadamard.sv */
`default_nettype none

module tq_dc_hadamard
    import tq_dc_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,

    // wishbone classic slave
    input  wire logic      wb_cyc_i,
    input  wire logic      wb_stb_i,
    input  wire logic      wb_we_i,
    input  wire dc_block_t wb_dat_i,
    output logic           wb_ack_o,

    // fifo write side
    output logic           push_o,
    output dc_block_t      push_dat_o,
    input  wire logic      full_i
);

    logic      ack_q;
    logic      accept;
    dc_block_t xform;
    dc_block_t blk_q;

    // butterfly intermediates
    coeff_t    sum0;
    coeff_t    dif0;
    coeff_t    sum1;
    coeff_t    dif1;

    // no acceptance during the ack cycle so a held stb is not taken twice
    assign accept = wb_cyc_i && wb_stb_i && wb_we_i && !full_i && !ack_q;

    // 2x2 hadamard as two butterfly stages
    always_comb begin
        sum0 = wb_dat_i.c00 + wb_dat_i.c01;
        dif0 = wb_dat_i.c00 - wb_dat_i.c01;
        sum1 = wb_dat_i.c10 + wb_dat_i.c11;
        dif1 = wb_dat_i.c10 - wb_dat_i.c11;

        xform.qp  = wb_dat_i.qp;
        xform.c00 = sum0 + sum1;
        xform.c01 = dif0 + dif1;
        xform.c10 = sum0 - sum1;
        xform.c11 = dif0 - dif1;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;
        end
    end

    // transformed block captured on acceptance and pushed during the ack cycle
    always_ff @(posedge clk_i) begin
        if (accept) begin
            blk_q <= xform;
        end
    end

    assign wb_ack_o   = ack_q;
    assign push_o     = ack_q;
    assign push_dat_o = blk_q;

endmodule

`default_nettype wire

/* logic/tq_dc_fifo.sv */
`default_nettype none

module tq_dc_fifo
    import tq_dc_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,

    // write side
    input  wire logic      push_i,
    input  wire dc_block_t push_dat_i,
    output logic           full_o,

    // first-word fall-through read side
    input  wire logic      pop_i,
    output dc_block_t      pop_dat_o,
    output logic           empty_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    dc_block_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count == CNT_W'(FIFO_DEPTH));
    assign empty_o = (count == '0);

    // requests against a full or empty buffer are dropped
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= push_dat_i;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign pop_dat_o = mem[rd_ptr];

endmodule

`default_nettype wire

/* logic/tq_quant_2x2.sv */
`default_nettype none

module tq_quant_2x2
    import tq_dc_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,

    // fifo read side
    input  wire logic      empty_i,
    input  wire dc_block_t pop_dat_i,
    output logic           pop_o,

    // wishbone classic master
    output logic           wb_cyc_o,
    output logic           wb_stb_o,
    output logic           wb_we_o,
    output level_block_t   wb_dat_o,
    input  wire logic      wb_ack_i
);

    typedef logic [3:0]  qp_div_t;
    typedef logic [2:0]  qp_mod_t;
    typedef logic [13:0] mf_t;
    typedef logic [4:0]  shift_t;

    typedef enum logic {
        IDLE,
        WRITE
    } state_t;

    state_t       state_q;
    qp_t          qp;
    qp_div_t      qp_div6;
    qp_mod_t      qp_mod6;
    logic [5:0]   qp_base;
    mf_t          mf;
    shift_t       shift;
    level_block_t levels;
    level_block_t dat_q;

    // magnitude times factor, shifted, rounded half up, sign restored
    function automatic level_t quantize(input coeff_t coeff, input mf_t mf_in,
                                        input shift_t sh);
        logic [14:0] mag;
        logic [28:0] prod;
        logic [28:0] pre;
        logic [29:0] rnd;
        logic [14:0] lvl_abs;
        mag     = coeff[14] ? 15'(~coeff + 1'b1) : 15'(coeff);
        prod    = mag * mf_in;
        // keep one extra bit below the final lsb for rounding
        pre     = prod >> sh;
        rnd     = {1'b0, pre} + 30'd1;
        lvl_abs = rnd[15:1];
        return coeff[14] ? level_t'(~lvl_abs + 1'b1) : level_t'(lvl_abs);
    endfunction

    assign qp = pop_dat_i.qp;

    // qp div 6 by threshold compares since qp is at most 51
    always_comb begin
        if (qp >= 6'd48) begin
            qp_div6 = 4'd8;
        end else if (qp >= 6'd42) begin
            qp_div6 = 4'd7;
        end else if (qp >= 6'd36) begin
            qp_div6 = 4'd6;
        end else if (qp >= 6'd30) begin
            qp_div6 = 4'd5;
        end else if (qp >= 6'd24) begin
            qp_div6 = 4'd4;
        end else if (qp >= 6'd18) begin
            qp_div6 = 4'd3;
        end else if (qp >= 6'd12) begin
            qp_div6 = 4'd2;
        end else if (qp >= 6'd6) begin
            qp_div6 = 4'd1;
        end else begin
            qp_div6 = 4'd0;
        end
    end

    assign qp_base = {2'b00, qp_div6} * 6'd6;
    assign qp_mod6 = qp_mod_t'(qp - qp_base);

    // shift of 15 + qp/6 leaves the last bit of the 16 + qp/6 shift to rounding
    assign shift = 5'd15 + {1'b0, qp_div6};

    always_comb begin
        case (qp_mod6)
            3'd0:    mf = 14'd13107;
            3'd1:    mf = 14'd11916;
            3'd2:    mf = 14'd10082;
            3'd3:    mf = 14'd9362;
            3'd4:    mf = 14'd8192;
            3'd5:    mf = 14'd7282;
            default: mf = 14'd0;
        endcase
    end

    always_comb begin
        levels.l00 = quantize(pop_dat_i.c00, mf, shift);
        levels.l01 = quantize(pop_dat_i.c01, mf, shift);
        levels.l10 = quantize(pop_dat_i.c10, mf, shift);
        levels.l11 = quantize(pop_dat_i.c11, mf, shift);
    end

    assign pop_o = (state_q == IDLE) && !empty_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (!empty_i) begin
                        state_q <= WRITE;
                    end
                end
                WRITE: begin
                    // cycle ends where ack is sampled high
                    if (wb_ack_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // output block held stable for the whole bus cycle
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            dat_q <= levels;
        end
    end

    assign wb_cyc_o = (state_q == WRITE);
    assign wb_stb_o = (state_q == WRITE);
    assign wb_we_o  = (state_q == WRITE);
    assign wb_dat_o = dat_q;

endmodule

`default_nettype wire

/* logic/tq_dc_top.sv */
`default_nettype none

module tq_dc_top
    import tq_dc_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         arst_n_i,

    // host side, wishbone classic slave
    input  wire logic         in_cyc_i,
    input  wire logic         in_stb_i,
    input  wire logic         in_we_i,
    input  wire dc_block_t    in_dat_i,
    output logic              in_ack_o,

    // sink side, wishbone classic master
    output logic              out_cyc_o,
    output logic              out_stb_o,
    output logic              out_we_o,
    output level_block_t      out_dat_o,
    input  wire logic         out_ack_i
);

    // blocks buffered between transform and quantizer
    localparam int FIFO_DEPTH = 4;

    logic      push;
    dc_block_t push_dat;
    logic      full;
    logic      pop;
    dc_block_t pop_dat;
    logic      empty;

    tq_dc_hadamard u_hadamard (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .wb_cyc_i   (in_cyc_i),
        .wb_stb_i   (in_stb_i),
        .wb_we_i    (in_we_i),
        .wb_dat_i   (in_dat_i),
        .wb_ack_o   (in_ack_o),
        .push_o     (push),
        .push_dat_o (push_dat),
        .full_i     (full)
    );

    tq_dc_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .push_i     (push),
        .push_dat_i (push_dat),
        .full_o     (full),
        .pop_i      (pop),
        .pop_dat_o  (pop_dat),
        .empty_o    (empty)
    );

    tq_quant_2x2 u_quant (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .empty_i    (empty),
        .pop_dat_i  (pop_dat),
        .pop_o      (pop),
        .wb_cyc_o   (out_cyc_o),
        .wb_stb_o   (out_stb_o),
        .wb_we_o    (out_we_o),
        .wb_dat_o   (out_dat_o),
        .wb_ack_i   (out_ack_i)
    );

endmodule

`default_nettype wire

/* dv/tq_dc_assertions.sv */
`default_nettype none

module tq_dc_assertions
    import tq_dc_pkg::*;
(
    input wire logic         clk_i,
    input wire logic         arst_n_i,
    input wire logic         in_cyc_i,
    input wire logic         in_stb_i,
    input wire logic         in_ack_o,
    input wire logic         out_cyc_o,
    input wire logic         out_stb_o,
    input wire level_block_t out_dat_o,
    input wire logic         out_ack_i
);

    // slave ack only answers a live request
    property ack_with_request;
        @(posedge clk_i) disable iff (!arst_n_i)
            in_ack_o |-> (in_cyc_i && in_stb_i);
    endproperty

    // master keeps the request and its data until the sink acks
    property out_held_until_ack;
        @(posedge clk_i) disable iff (!arst_n_i)
            (out_stb_o && !out_ack_i) |=> (out_stb_o && $stable(out_dat_o));
    endproperty

    property stb_inside_cyc;
        @(posedge clk_i) disable iff (!arst_n_i)
            out_stb_o |-> out_cyc_o;
    endproperty

    assert property (ack_with_request)
        else $error("in_ack_o high without in_cyc_i and in_stb_i");
    assert property (out_held_until_ack)
        else $error("out_stb_o or out_dat_o changed before out_ack_i");
    assert property (stb_inside_cyc)
        else $error("out_stb_o high without out_cyc_o");

endmodule

`default_nettype wire

/* dv/tq_dc_tb.sv */
`default_nettype none

module tq_dc_tb
    import tq_dc_pkg::*;
();

    localparam int CLK_PERIOD         = 100;
    localparam int DRIVE_DELAY        = 10;
    localparam int RESET_CYCLES       = 10;
    localparam int NUM_PATTERNS       = 19;
    localparam int WORDS_PER_PATTERN  = 9;
    localparam int CYCLES_PER_PATTERN = 200;
    localparam int MAX_ACK_DELAY      = 12;

    logic         clk;
    logic         arst_n;
    logic         in_cyc;
    logic         in_stb;
    logic         in_we;
    dc_block_t    in_dat;
    logic         in_ack;
    logic         out_cyc;
    logic         out_stb;
    logic         out_we;
    level_block_t out_dat;
    logic         out_ack;

    logic [15:0]  pattern_mem [NUM_PATTERNS*WORDS_PER_PATTERN];
    level_block_t expected_q [$];
    int           checked_count;
    bit           stall_seen;

    tq_dc_top u_dut (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .in_cyc_i  (in_cyc),
        .in_stb_i  (in_stb),
        .in_we_i   (in_we),
        .in_dat_i  (in_dat),
        .in_ack_o  (in_ack),
        .out_cyc_o (out_cyc),
        .out_stb_o (out_stb),
        .out_we_o  (out_we),
        .out_dat_o (out_dat),
        .out_ack_i (out_ack)
    );

    bind tq_dc_top tq_dc_assertions u_assertions (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .in_cyc_i  (in_cyc_i),
        .in_stb_i  (in_stb_i),
        .in_ack_o  (in_ack_o),
        .out_cyc_o (out_cyc_o),
        .out_stb_o (out_stb_o),
        .out_dat_o (out_dat_o),
        .out_ack_i (out_ack_i)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic compare_value(input string name, input logic [14:0] expected,
                                 input logic [14:0] actual);
        assert (actual === expected) else begin
            $display("ERR t=%0t %s expected %0d got %0d", $time, name,
                     $signed(expected), $signed(actual));
            stop_with_failure("value mismatch on a DUT output");
        end
    endtask

    task automatic check_idle_outputs();
        compare_value("in_ack_o", 15'd0, 15'(in_ack));
        compare_value("out_cyc_o", 15'd0, 15'(out_cyc));
        compare_value("out_stb_o", 15'd0, 15'(out_stb));
    endtask

    // record layout is qp, four raw coefficients and four expected levels
    function automatic dc_block_t pattern_input(input int idx);
        int        base;
        dc_block_t blk;
        base    = idx * WORDS_PER_PATTERN;
        blk.qp  = pattern_mem[base][5:0];
        blk.c00 = pattern_mem[base+1][14:0];
        blk.c01 = pattern_mem[base+2][14:0];
        blk.c10 = pattern_mem[base+3][14:0];
        blk.c11 = pattern_mem[base+4][14:0];
        return blk;
    endfunction

    function automatic level_block_t pattern_levels(input int idx);
        int           base;
        level_block_t lvl;
        base    = idx * WORDS_PER_PATTERN;
        lvl.l00 = pattern_mem[base+5][14:0];
        lvl.l01 = pattern_mem[base+6][14:0];
        lvl.l10 = pattern_mem[base+7][14:0];
        lvl.l11 = pattern_mem[base+8][14:0];
        return lvl;
    endfunction

    // request held until ack and the next block follows right after
    task automatic send_block(input int idx);
        int waited;
        waited = 0;
        in_cyc = 1'b1;
        in_stb = 1'b1;
        in_we  = 1'b1;
        in_dat = pattern_input(idx);
        expected_q.push_back(pattern_levels(idx));
        do begin
            @(posedge clk);
            waited++;
        end while (!in_ack);
        // without a full fifo the ack shows on the second edge
        if (waited > 2) begin
            stall_seen = 1'b1;
        end
        #DRIVE_DELAY;
    endtask

    task automatic check_output_block();
        level_block_t expected;
        assert (expected_q.size() > 0) else begin
            stop_with_failure("output block arrived with no input block pending");
        end
        expected = expected_q.pop_front();
        compare_value("out_cyc_o", 15'd1, 15'(out_cyc));
        compare_value("out_we_o", 15'd1, 15'(out_we));
        compare_value("out_dat_o.l00", expected.l00, out_dat.l00);
        compare_value("out_dat_o.l01", expected.l01, out_dat.l01);
        compare_value("out_dat_o.l10", expected.l10, out_dat.l10);
        compare_value("out_dat_o.l11", expected.l11, out_dat.l11);
        checked_count++;
    endtask

    // sink with a random ack delay per block
    initial begin : sink
        int delay;
        wait (arst_n === 1'b1);
        forever begin
            @(posedge clk);
            if (out_stb) begin
                delay = $urandom_range(MAX_ACK_DELAY, 0);
                repeat (delay) @(posedge clk);
                #DRIVE_DELAY;
                out_ack = 1'b1;
                @(posedge clk);
                check_output_block();
                #DRIVE_DELAY;
                out_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (RESET_CYCLES + NUM_PATTERNS * CYCLES_PER_PATTERN));
        stop_with_failure("timeout, not all blocks came out of the DUT in time");
    end

    initial begin : main
        void'($urandom(32'hc9a2));
        arst_n        = 1'b0;
        in_cyc        = 1'b0;
        in_stb        = 1'b0;
        in_we         = 1'b0;
        in_dat        = '0;
        out_ack       = 1'b0;
        checked_count = 0;
        stall_seen    = 1'b0;
        $readmemh("dv/tq_dc_patterns.hex", pattern_mem);

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            check_idle_outputs();
        end
        #DRIVE_DELAY;
        arst_n = 1'b1;
        @(posedge clk);
        check_idle_outputs();
        #DRIVE_DELAY;

        for (int i = 0; i < NUM_PATTERNS; i++) begin
            send_block(i);
        end
        in_cyc = 1'b0;
        in_stb = 1'b0;
        in_we  = 1'b0;

        wait (checked_count == NUM_PATTERNS);
        // nothing may follow the last block
        repeat (4) begin
            @(posedge clk);
            assert (!out_cyc) else begin
                stop_with_failure("extra output block after the last pattern");
            end
        end
        assert (stall_seen) else begin
            stop_with_failure("input ack never stalled under sink back-pressure");
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tq_dc.f */
logic/tq_dc_pkg.sv
logic/tq_dc_hadamard.sv
logic/tq_dc_fifo.sv
logic/tq_quant_2x2.sv
logic/tq_dc_top.sv
dv/tq_dc_assertions.sv
dv/tq_dc_tb.sv

/* Makefile */
VERILATOR := verilator
TOP       := tq_dc_tb
FILELIST  := tq_dc.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* dv/tq_dc_patterns.hex */
// qp c00 c01 c10 c11 then expected l00 l01 l10 l11, one block per line
// coefficients and levels are 16-bit two's complement, bits 14:0 are used
00 0000 0000 0000 0000 0000 0000 0000 0000
00 0064 0000 0000 0000 0014 0014 0014 0014
04 0003 ffff 0000 0000 0000 0001 0000 0001
04 fffd 0001 0000 0000 0000 ffff 0000 ffff
0a 000c 0000 0000 fff4 0000 0002 0002 0000
0a fff4 0000 0000 000c 0000 fffe fffe 0000
07 01f4 fed4 0000 0000 0012 0049 0012 0049
0e fc18 fc18 0000 0000 ffb3 0000 ffb3 0000
15 0fff 0fff 0fff 0fff 0124 0000 0000 0000
1c ffa0 ffa0 0000 0000 fffe 0000 fffe 0000
1c 00a0 ffe0 0000 0000 0001 0002 0001 0002
23 07d0 fc18 0000 0000 0003 000a 0003 000a
24 f060 0000 0000 0000 fff4 fff4 fff4 fff4
2b 0bb8 0bb8 f448 f448 0000 0000 0011 0000
32 0fa0 f060 0fa0 f060 0000 000a 0000 0000
33 f001 f001 f001 f001 fff7 0000 0000 0000
2f 04d2 fdc9 0000 0000 0001 0002 0001 0002
19 fd44 012c 0000 0000 fffb fff5 fffb fff5
10 0008 ffd8 0000 0000 ffff 0002 ffff 0002
